// ==== logic/imuldiv_pkg.sv ====
/*
  imuldiv package: shared widths, iteration count and the enums
  used by the iterative multiply/divide unit
*/

package imuldiv_pkg;

  // --------------------------------------------------
  // widths and iteration count
  // --------------------------------------------------

  // operand width, results are twice this
  localparam int xlen = 32;

  // one shift iteration per operand bit
  localparam int iter_count = 32;

  // counter must hold values up to iter_count
  localparam int cnt_w = 6;

  // --------------------------------------------------
  // encodings
  // --------------------------------------------------

  // request opcodes
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_div  = 2'd1,
    op_divu = 2'd2
  } imuldiv_op_e;

  // control FSM states
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } imuldiv_state_e;

endpackage

// ==== logic/imuldiv_ctrl.sv ====
/*
  imuldiv control: idle/calc/done FSM with the iteration counter,
  datapath load strobes and the response result select
*/

module imuldiv_ctrl (
  input  logic                             clk,
  input  logic                             reset,
  input  imuldiv_pkg::imuldiv_op_e         req_op,
  input  logic                             req_val,
  output logic                             req_rdy,
  output logic                             resp_val,
  input  logic                             resp_rdy,
  output logic [2*imuldiv_pkg::xlen-1:0]   resp_result,
  input  logic [2*imuldiv_pkg::xlen-1:0]   mul_result,
  input  logic [2*imuldiv_pkg::xlen-1:0]   div_result,
  output logic                             load_mul,
  output logic                             load_div,
  output logic                             div_signed,
  output logic                             step
);

  import imuldiv_pkg::*;

  imuldiv_state_e   state;
  logic [cnt_w-1:0] count;
  imuldiv_op_e      op_reg;
  logic             req_go;
  logic             resp_go;

  // handshakes on both channels
  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------------------------------------
  // state, counter and opcode register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= st_idle;
      count  <= '0;
      op_reg <= op_mul;
    end else begin
      case (state)
        st_idle: begin
          // accept a request and remember what it was
          if (req_go) begin
            state  <= st_calc;
            count  <= '0;
            op_reg <= req_op;
          end
        end
        st_calc: begin
          // last step cycle, result is complete after this edge
          if (count == cnt_w'(iter_count - 1)) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          // hold result until the consumer takes it
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // outputs decoded from state
  // --------------------------------------------------

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    step     = 1'b0;
    case (state)
      st_idle: req_rdy  = 1'b1;
      st_calc: step     = 1'b1;
      st_done: resp_val = 1'b1;
      default: req_rdy  = 1'b0;
    endcase
  end

  // load pulses come straight from the incoming opcode on the accept cycle
  assign load_mul   = req_go && (req_op == op_mul);
  assign load_div   = req_go && ((req_op == op_div) || (req_op == op_divu));
  assign div_signed = (req_op == op_div);

  // registered opcode picks which datapath answers
  assign resp_result = (op_reg == op_mul) ? mul_result : div_result;

endmodule

// ==== logic/imuldiv_mul_dpath.sv ====
/*
  imuldiv multiply datapath: signed shift-add multiplier working on
  operand magnitudes, with the product sign applied at the output
*/

module imuldiv_mul_dpath (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             load_mul,
  input  logic                             step,
  input  logic [imuldiv_pkg::xlen-1:0]     req_a,
  input  logic [imuldiv_pkg::xlen-1:0]     req_b,
  output logic [2*imuldiv_pkg::xlen-1:0]   mul_result
);

  import imuldiv_pkg::*;

  // multiplicand, widened so it can shift left across the full product
  logic [2*xlen-1:0] a_reg;
  // multiplier, consumed one bit per step from the bottom
  logic [xlen-1:0]   b_reg;
  // running partial product
  logic [2*xlen-1:0] acc;
  // set when exactly one operand was negative
  logic              prod_neg;
  logic [xlen-1:0]   a_mag;
  logic [xlen-1:0]   b_mag;

  // --------------------------------------------------
  // magnitude conversion at load
  // --------------------------------------------------

  // two's complement negate when the sign bit is set
  assign a_mag = req_a[xlen-1] ? (~req_a + 1'b1) : req_a;
  assign b_mag = req_b[xlen-1] ? (~req_b + 1'b1) : req_b;

  // --------------------------------------------------
  // operand shift registers
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (load_mul) begin
      a_reg <= {{xlen{1'b0}}, a_mag};
      b_reg <= b_mag;
    end else if (step) begin
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // --------------------------------------------------
  // accumulator and sign flag
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      acc      <= '0;
      prod_neg <= 1'b0;
    end else if (load_mul) begin
      acc      <= '0;
      prod_neg <= req_a[xlen-1] ^ req_b[xlen-1];
    end else if (step && b_reg[0]) begin
      // add the shifted multiplicand for each set multiplier bit
      acc <= acc + a_reg;
    end
  end

  // sign fix on the way out
  assign mul_result = prod_neg ? (~acc + 1'b1) : acc;

endmodule

// ==== logic/imuldiv_div_dpath.sv ====
/*
  imuldiv divide datapath: restoring shift-subtract divider, signed or
  unsigned, returning {remainder, quotient}
*/

module imuldiv_div_dpath (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             load_div,
  input  logic                             div_signed,
  input  logic                             step,
  input  logic [imuldiv_pkg::xlen-1:0]     req_a,
  input  logic [imuldiv_pkg::xlen-1:0]     req_b,
  output logic [2*imuldiv_pkg::xlen-1:0]   div_result
);

  import imuldiv_pkg::*;

  // remainder in the upper half, dividend/quotient in the lower half
  logic [2*xlen-1:0] rq;
  logic [xlen-1:0]   divisor;
  logic              quo_neg;
  logic              rem_neg;
  logic              div_zero;
  logic              a_neg;
  logic              b_neg;
  logic [xlen-1:0]   a_mag;
  logic [xlen-1:0]   b_mag;
  logic [2*xlen-1:0] rq_shift;
  // one extra bit so the top remainder bit is not lost on the shift
  logic [xlen:0]     trial;
  logic [xlen-1:0]   quo;
  logic [xlen-1:0]   rem;

  // --------------------------------------------------
  // operand conversion
  // --------------------------------------------------

  // sign bits only count for the signed opcode
  assign a_neg = div_signed && req_a[xlen-1];
  assign b_neg = div_signed && req_b[xlen-1];
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  // --------------------------------------------------
  // one restoring iteration
  // --------------------------------------------------

  assign rq_shift = {rq[2*xlen-2:0], 1'b0};
  // shifted remainder minus divisor, msb is the borrow
  assign trial = rq[2*xlen-1:xlen-1] - {1'b0, divisor};

  always_ff @(posedge clk) begin
    if (load_div) begin
      divisor <= b_mag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rq       <= '0;
      quo_neg  <= 1'b0;
      rem_neg  <= 1'b0;
      div_zero <= 1'b0;
    end else if (load_div) begin
      rq       <= {{xlen{1'b0}}, a_mag};
      quo_neg  <= a_neg ^ b_neg;
      // remainder follows the dividend
      rem_neg  <= a_neg;
      div_zero <= (req_b == '0);
    end else if (step) begin
      if (!trial[xlen]) begin
        // subtract fits, keep the difference and set the quotient bit
        rq <= {trial[xlen-1:0], rq_shift[xlen-1:1], 1'b1};
      end else begin
        // restore: shift only, quotient bit stays zero
        rq <= rq_shift;
      end
    end
  end

  // --------------------------------------------------
  // sign fix and divide-by-zero
  // --------------------------------------------------

  assign quo = rq[xlen-1:0];
  assign rem = rq[2*xlen-1:xlen];

  // a zero divisor leaves an all-ones quotient and the dividend magnitude
  // as remainder, so only the remainder sign is restored
  assign div_result = {rem_neg ? (~rem + 1'b1) : rem,
                       (quo_neg && !div_zero) ? (~quo + 1'b1) : quo};

endmodule

// ==== logic/imuldiv_unit.sv ====
/*
  imuldiv top: iterative integer multiply/divide unit with valid/ready
  request and response channels
*/

module imuldiv_unit (
  input  logic                             clk,
  input  logic                             reset,
  input  imuldiv_pkg::imuldiv_op_e         req_op,
  input  logic [imuldiv_pkg::xlen-1:0]     req_a,
  input  logic [imuldiv_pkg::xlen-1:0]     req_b,
  input  logic                             req_val,
  output logic                             req_rdy,
  output logic [2*imuldiv_pkg::xlen-1:0]   resp_result,
  output logic                             resp_val,
  input  logic                             resp_rdy
);

  import imuldiv_pkg::*;

  // datapath results back to control
  logic [2*xlen-1:0] mul_result;
  logic [2*xlen-1:0] div_result;
  // control strobes to the datapaths
  logic              load_mul;
  logic              load_div;
  logic              div_signed;
  logic              step;

  // --------------------------------------------------
  // sequencing and result select
  // --------------------------------------------------

  imuldiv_ctrl ctrl_i (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result),
    .mul_result  (mul_result),
    .div_result  (div_result),
    .load_mul    (load_mul),
    .load_div    (load_div),
    .div_signed  (div_signed),
    .step        (step)
  );

  // --------------------------------------------------
  // datapaths, both step together
  // --------------------------------------------------

  imuldiv_mul_dpath mul_i (
    .clk        (clk),
    .reset      (reset),
    .load_mul   (load_mul),
    .step       (step),
    .req_a      (req_a),
    .req_b      (req_b),
    .mul_result (mul_result)
  );

  imuldiv_div_dpath div_i (
    .clk        (clk),
    .reset      (reset),
    .load_div   (load_div),
    .div_signed (div_signed),
    .step       (step),
    .req_a      (req_a),
    .req_b      (req_b),
    .div_result (div_result)
  );

endmodule

// ==== tests/imuldiv_checker.sv ====
/*
  imuldiv checker: handshake, result hold and fixed latency assertions
*/

module imuldiv_checker (
  input logic                             clk,
  input logic                             reset,
  input logic                             req_val,
  input logic                             req_rdy,
  input logic                             resp_val,
  input logic                             resp_rdy,
  input logic [2*imuldiv_pkg::xlen-1:0]   resp_result,
  input imuldiv_pkg::imuldiv_state_e      state
);

  timeunit 1ns;
  timeprecision 100ps;

  import imuldiv_pkg::*;

  // only one operation in flight, so the two channels never open together
  assert property (@(posedge clk) disable iff (reset) !(req_rdy && resp_val))
    else $error("req_rdy and resp_val high in the same cycle");

  // result held while the consumer stalls
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp_result))
    else $error("resp_result changed under back-pressure");

  // accept, then iter_count calc cycles, then the response appears
  assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) |=> (state == st_calc && !resp_val)[*iter_count]
      ##1 (state == st_done && resp_val))
    else $error("response latency differs from iter_count + 1 cycles");

endmodule

bind imuldiv_unit imuldiv_checker chk_i (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result),
  .state       (ctrl_i.state)
);

// ==== tests/imuldiv_tb.sv ====
/*
  imuldiv testbench with directed multiply, divide, divide-by-zero,
  back-pressure and back-to-back tests against a reference model
*/

module imuldiv_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import imuldiv_pkg::*;

  logic              clk = 1'b0;
  logic              reset;
  imuldiv_op_e       req_op;
  logic [xlen-1:0]   req_a;
  logic [xlen-1:0]   req_b;
  logic              req_val;
  logic              req_rdy;
  logic [2*xlen-1:0] resp_result;
  logic              resp_val;
  logic              resp_rdy;
  int                errors = 0;
  int                checks = 0;
  int                tests = 0;
  // cycles any single wait may take before giving up
  int                wait_limit = 100;

  imuldiv_unit dut_i (.*);

  always #10 clk = ~clk;

  // --------------------------------------------------
  // reference model and checking
  // --------------------------------------------------

  // 64-bit signed arithmetic where / and % truncate toward zero
  function automatic logic [2*xlen-1:0] model_result(imuldiv_op_e op, logic [xlen-1:0] a,
                                                     logic [xlen-1:0] b);
    logic signed [2*xlen-1:0] sa;
    logic signed [2*xlen-1:0] sb;
    logic signed [2*xlen-1:0] q;
    logic signed [2*xlen-1:0] r;
    sa = $signed(a);
    sb = $signed(b);
    if (op == op_divu) begin
      sa = {{xlen{1'b0}}, a};
      sb = {{xlen{1'b0}}, b};
    end
    if (op == op_mul) begin
      q = sa * sb;
    end else if (b == '0) begin
      // zero divisor gives the dividend as remainder and an all-ones quotient
      q = {a, {xlen{1'b1}}};
    end else begin
      r = sa % sb;
      q = sa / sb;
      q = {r[xlen-1:0], q[xlen-1:0]};
    end
    return q;
  endfunction

  task automatic check_value(string what, logic [2*xlen-1:0] got, logic [2*xlen-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(string what);
    errors++;
    $display("Timeout at %0t: %s within %0d cycles", $time, what, wait_limit);
  endtask

  // --------------------------------------------------
  // channel drivers
  // --------------------------------------------------

  // all driving and sampling happens 2 ns after a rising edge
  task automatic send_request(imuldiv_op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    int cycles = 0;
    req_op  = op;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    while (!req_rdy && cycles < wait_limit) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!req_rdy) begin
      report_timeout("request was not accepted");
    end else begin
      // transfer edge
      @(posedge clk);
      #2;
    end
    req_val = 1'b0;
  endtask

  // called right after the accepting edge and counts edges up to resp_val
  task automatic collect_response(imuldiv_op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    int cycles = 0;
    while (!resp_val && cycles < wait_limit) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!resp_val) begin
      report_timeout("no response arrived");
    end else begin
      // resp_val rises on the edge that ends the last calc cycle
      check_value("latency", cycles, iter_count);
      check_value($sformatf("%s a=%h b=%h", op.name(), a, b), resp_result,
                  model_result(op, a, b));
    end
  endtask

  // full operation with resp_rdy already high
  task automatic run_op(imuldiv_op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    send_request(op, a, b);
    collect_response(op, a, b);
    @(posedge clk);
    #2;
    check_value("resp_val after transfer", resp_val, 1'b0);
    check_value("req_rdy after transfer", req_rdy, 1'b1);
  endtask

  task automatic report_test(string name, int start_errors);
    tests++;
    $display("test %-12s finished with %0d errors", name, errors - start_errors);
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------

  task automatic test_reset();
    int start = errors;
    check_value("req_rdy after reset", req_rdy, 1'b1);
    check_value("resp_val after reset", resp_val, 1'b0);
    report_test("reset", start);
  endtask

  // corner operands with zero, +-1, most negative, mixed signs and small divides
  task automatic test_arith(imuldiv_op_e op);
    logic [xlen-1:0] a_tab [8] = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000,
                                   32'h80000000, 32'h3039, 32'hfffffff9, 32'h64};
    logic [xlen-1:0] b_tab [8] = '{32'h5, 32'hffffffff, 32'hffffffff, 32'h80000000,
                                   32'hffffffff, 32'hfffffd5a, 32'h9, 32'h7};
    int start = errors;
    for (int i = 0; i < 8; i++) begin
      run_op(op, a_tab[i], b_tab[i]);
    end
    // random operands with the divisor narrowed now and then for bigger quotients
    for (int i = 0; i < 8; i++) begin
      run_op(op, $urandom(), $urandom() >> $urandom_range(0, 24));
    end
    report_test(op.name(), start);
  endtask

  task automatic test_div_zero();
    logic [xlen-1:0] a_tab [4] = '{32'h4d2, 32'hfffffb2e, 32'h80000000, 32'h0};
    int start = errors;
    for (int i = 0; i < 4; i++) begin
      run_op(op_div, a_tab[i], '0);
      run_op(op_divu, a_tab[i], '0);
    end
    report_test("div_zero", start);
  endtask

  task automatic test_backpressure();
    logic [2*xlen-1:0] held;
    int                hold_cycles = $urandom_range(3, 15);
    int                start = errors;
    resp_rdy = 1'b0;
    send_request(op_mul, 32'hfffff000, 32'h12345);
    collect_response(op_mul, 32'hfffff000, 32'h12345);
    held = resp_result;
    // offer the next request while the unit is stalled
    req_op  = op_div;
    req_a   = 32'h8765;
    req_b   = 32'hfffffffd;
    req_val = 1'b1;
    repeat (hold_cycles) begin
      @(posedge clk);
      #2;
      check_value("resp_val held", resp_val, 1'b1);
      check_value("req_rdy under stall", req_rdy, 1'b0);
      check_value("result held", resp_result, held);
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    #2;
    // response gone and the pending request not yet taken
    check_value("resp_val after release", resp_val, 1'b0);
    check_value("req_rdy after release", req_rdy, 1'b1);
    send_request(op_div, 32'h8765, 32'hfffffffd);
    collect_response(op_div, 32'h8765, 32'hfffffffd);
    @(posedge clk);
    #2;
    report_test("backpressure", start);
  endtask

  task automatic test_back_to_back();
    int start = errors;
    resp_rdy = 1'b1;
    for (int i = 0; i < 6; i++) begin
      run_op(op_mul, $urandom(), $urandom());
      run_op((i % 2) ? op_divu : op_div, $urandom(), $urandom() >> 8);
    end
    report_test("back_to_back", start);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(32'h9fa891c7));
    reset    = 1'b1;
    req_op   = op_mul;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset();
    test_arith(op_mul);
    test_arith(op_div);
    test_arith(op_divu);
    test_div_zero();
    test_backpressure();
    test_back_to_back();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== list.f ====
logic/imuldiv_pkg.sv
logic/imuldiv_ctrl.sv
logic/imuldiv_mul_dpath.sv
logic/imuldiv_div_dpath.sv
logic/imuldiv_unit.sv
tests/imuldiv_checker.sv
tests/imuldiv_tb.sv
